// File: rtl/ctrl_pkg.sv
// Shared types and constants for the decode control block.
// Every RTL module takes these with a wildcard import in its header.
`default_nettype none

package ctrl_pkg;

	////////////////////////////////
	// widths and fixed values
	////////////////////////////////
	localparam int INSN_W     = 32;
	localparam int REG_ADDR_W = 5;

	// r9 holds the return address of jump-and-link
	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd9;

	// nop opcode with bit 16 set marks a pipeline bubble
	localparam logic [INSN_W-1:0] NOP_INSN = 32'h1541_0000;

	////////////////////////////////
	// major opcodes, bits 31:26
	////////////////////////////////
	typedef enum logic [5:0] {
		OP_J       = 6'h00,
		OP_JAL     = 6'h01,
		OP_BNF     = 6'h03,
		OP_BF      = 6'h04,
		OP_NOP     = 6'h05,
		OP_MOVHI   = 6'h06,
		OP_XSYNC   = 6'h08,
		OP_RFE     = 6'h09,
		OP_JR      = 6'h11,
		OP_JALR    = 6'h12,
		OP_LWZ     = 6'h21,
		OP_LWS     = 6'h22,
		OP_LBZ     = 6'h23,
		OP_LBS     = 6'h24,
		OP_LHZ     = 6'h25,
		OP_LHS     = 6'h26,
		OP_ADDI    = 6'h27,
		OP_ADDIC   = 6'h28,
		OP_ANDI    = 6'h29,
		OP_ORI     = 6'h2A,
		OP_XORI    = 6'h2B,
		OP_MULI    = 6'h2C,
		OP_MFSPR   = 6'h2D,
		OP_SH_ROTI = 6'h2E,
		OP_SFXXI   = 6'h2F,
		OP_MTSPR   = 6'h30,
		OP_SW      = 6'h35,
		OP_SB      = 6'h36,
		OP_SH      = 6'h37,
		OP_ALU     = 6'h38,
		OP_SFXX    = 6'h39
	} opcode_t;

	// alu operation, also the subop field of the register form
	typedef enum logic [4:0] {
		ALU_ADD   = 5'd0,
		ALU_ADDC  = 5'd1,
		ALU_SUB   = 5'd2,
		ALU_AND   = 5'd3,
		ALU_OR    = 5'd4,
		ALU_XOR   = 5'd5,
		ALU_MUL   = 5'd6,
		ALU_SHROT = 5'd8,
		ALU_DIV   = 5'd9,
		ALU_DIVU  = 5'd10,
		ALU_MULU  = 5'd11,
		ALU_MOVHI = 5'd14,
		ALU_COMP  = 5'd15,
		ALU_NOP   = 5'd16
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0,
		BR_J   = 3'd1,
		BR_JR  = 3'd2,
		BR_BF  = 3'd4,
		BR_BNF = 3'd5,
		BR_RFE = 3'd6
	} branch_op_t;

	// write-back source, bit 0 is the write enable
	typedef enum logic [2:0] {
		RFWB_NOP  = 3'd0,
		RFWB_ALU  = 3'd1,
		RFWB_LSU  = 3'd3,
		RFWB_SPRS = 3'd5,
		RFWB_LR   = 3'd7
	} rfwb_op_t;

	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_t;

endpackage

`default_nettype wire

// File: rtl/insn_pipe_latch.sv
// Instruction registers of the ID, EX and WB stages.
// Also forms the EX bubble condition used by the EX decoder.
`timescale 1ns/100ps
`default_nettype none

module insn_pipe_latch import ctrl_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              flushpipe,
	input  wire logic              id_freeze,
	input  wire logic              ex_freeze,
	input  wire logic              wb_freeze,
	input  wire logic [INSN_W-1:0] if_insn,
	output logic      [INSN_W-1:0] id_insn,
	output logic      [INSN_W-1:0] ex_insn,
	output logic      [INSN_W-1:0] wb_insn,
	output logic                   ex_bubble
);

	// ex runs on while id is held, or the pipe is flushed
	assign ex_bubble = (!ex_freeze && id_freeze) || flushpipe;

	always_ff @(posedge clk) begin
		if (reset)
			id_insn <= NOP_INSN;
		else if (flushpipe)
			id_insn <= NOP_INSN;
		else if (!id_freeze)
			id_insn <= if_insn;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ex_insn <= NOP_INSN;
		else if (ex_bubble)
			ex_insn <= NOP_INSN;
		else if (!ex_freeze)
			ex_insn <= id_insn;
	end

	// wb keeps the retiring insn even across a flush
	always_ff @(posedge clk) begin
		if (reset)
			wb_insn <= NOP_INSN;
		else if (!wb_freeze)
			wb_insn <= ex_insn;
	end

	flush_nop_id: assert property (@(posedge clk) disable iff (reset)
		flushpipe |=> (id_insn == NOP_INSN));

endmodule

`default_nettype wire

// File: rtl/id_decode.sv
// IF-to-ID decode of branch type and operand-B immediate use.
// The ID immediate is extended combinationally from the ID instruction.
`timescale 1ns/100ps
`default_nettype none

module id_decode import ctrl_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              flushpipe,
	input  wire logic              id_freeze,
	input  wire logic [INSN_W-1:0] if_insn,
	input  wire logic [INSN_W-1:0] id_insn,
	output branch_op_t             id_branch_op,
	output logic                   sel_imm,
	output logic      [INSN_W-1:0] id_simm
);

	////////////////////////////////
	// branch type
	////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset || flushpipe) begin
			id_branch_op <= BR_NOP;
		end else if (!id_freeze) begin
			case (if_insn[31:26])
				OP_J, OP_JAL:   id_branch_op <= BR_J;
				OP_JR, OP_JALR: id_branch_op <= BR_JR;
				OP_BF:          id_branch_op <= BR_BF;
				OP_BNF:         id_branch_op <= BR_BNF;
				OP_RFE:         id_branch_op <= BR_RFE;
				default:        id_branch_op <= BR_NOP;
			endcase
		end
	end

	// operand b from the immediate unless the insn reads rb
	always_ff @(posedge clk) begin
		if (reset) begin
			sel_imm <= 1'b0;
		end else if (!id_freeze) begin
			case (if_insn[31:26])
				OP_JALR, OP_JR, OP_RFE, OP_MFSPR, OP_MTSPR, OP_XSYNC,
				OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX, OP_NOP:
					sel_imm <= 1'b0;
				default:
					sel_imm <= 1'b1;
			endcase
		end
	end

	////////////////////////////////
	// immediate extension
	////////////////////////////////
	always_comb begin
		case (id_insn[31:26])
			OP_ADDI, OP_ADDIC, OP_MULI, OP_XORI, OP_SFXXI,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// spr number split around the rb field
			OP_MTSPR:
				id_simm = {16'b0, id_insn[25:21], id_insn[10:0]};
			// store offset, same split but signed
			OP_SW, OP_SB, OP_SH:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'b0, id_insn[15:0]};
		endcase
	end

	jr_no_imm: assert property (@(posedge clk) disable iff (reset)
		(!id_freeze && if_insn[31:26] == OP_JR) |=> !sel_imm);

endmodule

`default_nettype wire

// File: rtl/ex_decode.sv
// ID-to-EX decode of the execute control words.
// A bubble loads the inactive values; HAS_MUL and HAS_DIV decide which
// multiply and divide forms are legal.
`timescale 1ns/100ps
`default_nettype none

module ex_decode import ctrl_pkg::*; #(
	parameter bit HAS_MUL = 1'b1,
	parameter bit HAS_DIV = 1'b1
) (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  ex_freeze,
	input  wire logic                  ex_bubble,
	input  wire logic [INSN_W-1:0]     id_insn,
	input  wire branch_op_t            id_branch_op,
	input  wire logic [INSN_W-1:0]     id_simm,
	output alu_op_t                    alu_op,
	output rfwb_op_t                   rfwb_op,
	output logic      [REG_ADDR_W-1:0] rf_addrw,
	output branch_op_t                 ex_branch_op,
	output logic      [INSN_W-1:0]     ex_simm,
	output logic                       except_illegal,
	output logic                       sig_syscall,
	output logic                       sig_trap
);

	alu_op_t                 dec_alu_op;
	rfwb_op_t                dec_rfwb_op;
	logic                    dec_illegal;
	logic [REG_ADDR_W-1:0]   dec_addrw;
	alu_op_t                 alu_sub;

	// subop field of the register alu form
	assign alu_sub = alu_op_t'({1'b0, id_insn[3:0]});

	assign dec_addrw = (id_insn[31:26] == OP_JAL || id_insn[31:26] == OP_JALR) ?
		LINK_REG : id_insn[25:21];

	////////////////////////////////
	// opcode decode
	////////////////////////////////
	always_comb begin
		dec_alu_op  = ALU_NOP;
		dec_rfwb_op = RFWB_NOP;
		dec_illegal = 1'b0;
		case (id_insn[31:26])
			OP_J, OP_BNF, OP_BF, OP_NOP, OP_XSYNC, OP_RFE, OP_JR,
			OP_MTSPR, OP_SW, OP_SB, OP_SH: ;
			OP_JAL, OP_JALR: dec_rfwb_op = RFWB_LR;
			OP_MFSPR:        dec_rfwb_op = RFWB_SPRS;
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				dec_rfwb_op = RFWB_LSU;
			OP_MOVHI: begin
				dec_alu_op  = ALU_MOVHI;
				dec_rfwb_op = RFWB_ALU;
			end
			OP_ADDI: begin
				dec_alu_op  = ALU_ADD;
				dec_rfwb_op = RFWB_ALU;
			end
			OP_ADDIC: begin
				dec_alu_op  = ALU_ADDC;
				dec_rfwb_op = RFWB_ALU;
			end
			OP_ANDI: begin
				dec_alu_op  = ALU_AND;
				dec_rfwb_op = RFWB_ALU;
			end
			OP_ORI: begin
				dec_alu_op  = ALU_OR;
				dec_rfwb_op = RFWB_ALU;
			end
			OP_XORI: begin
				dec_alu_op  = ALU_XOR;
				dec_rfwb_op = RFWB_ALU;
			end
			OP_MULI: begin
				dec_alu_op  = HAS_MUL ? ALU_MUL : ALU_NOP;
				dec_rfwb_op = HAS_MUL ? RFWB_ALU : RFWB_NOP;
				dec_illegal = !HAS_MUL;
			end
			OP_SH_ROTI: begin
				dec_alu_op  = ALU_SHROT;
				dec_rfwb_op = RFWB_ALU;
			end
			OP_SFXX, OP_SFXXI: dec_alu_op = ALU_COMP;
			OP_ALU: begin
				dec_alu_op  = alu_sub;
				dec_rfwb_op = RFWB_ALU;
				// bit 4 and subops 7, 12, 13 are unused
				dec_illegal = id_insn[4] || id_insn[3:0] == 4'd7 ||
					id_insn[3:0] == 4'd12 || id_insn[3:0] == 4'd13 ||
					(!HAS_MUL && (alu_sub == ALU_MUL || alu_sub == ALU_MULU)) ||
					(!HAS_DIV && (alu_sub == ALU_DIV || alu_sub == ALU_DIVU));
			end
			default: dec_illegal = 1'b1;
		endcase
	end

	// ex control registers
	always_ff @(posedge clk) begin
		if (reset || ex_bubble) begin
			alu_op         <= ALU_NOP;
			rfwb_op        <= RFWB_NOP;
			rf_addrw       <= '0;
			ex_branch_op   <= BR_NOP;
			ex_simm        <= '0;
			except_illegal <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
		end else if (!ex_freeze) begin
			alu_op         <= dec_alu_op;
			rfwb_op        <= dec_rfwb_op;
			rf_addrw       <= dec_addrw;
			ex_branch_op   <= id_branch_op;
			ex_simm        <= id_simm;
			except_illegal <= dec_illegal;
			sig_syscall    <= (id_insn[31:23] == {OP_XSYNC, 3'b000});
			sig_trap       <= (id_insn[31:23] == {OP_XSYNC, 3'b010});
		end
	end

	bubble_no_wb: assert property (@(posedge clk) disable iff (reset)
		ex_bubble |=> (rfwb_op == RFWB_NOP));

endmodule

`default_nettype wire

// File: rtl/operand_forward.sv
// Operand source selection for both ALU operands.
// Compares the ID source fields with the EX and WB write addresses.
`timescale 1ns/100ps
`default_nettype none

module operand_forward import ctrl_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  wb_freeze,
	input  wire logic [INSN_W-1:0]     id_insn,
	input  wire logic                  sel_imm,
	input  wire logic [REG_ADDR_W-1:0] rf_addrw,
	input  wire rfwb_op_t              rfwb_op,
	input  wire logic                  wbforw_valid,
	output sel_t                       sel_a,
	output sel_t                       sel_b
);

	logic [REG_ADDR_W-1:0] wb_rfaddrw;

	// ex result wins over the older wb result
	function automatic sel_t forw_sel(input logic [REG_ADDR_W-1:0] src);
		if (src == rf_addrw && rfwb_op[0])
			return SEL_EX_FORW;
		else if (src == wb_rfaddrw && wbforw_valid)
			return SEL_WB_FORW;
		else
			return SEL_RF;
	endfunction

	// write address one stage behind ex
	always_ff @(posedge clk) begin
		if (reset)
			wb_rfaddrw <= '0;
		else if (!wb_freeze)
			wb_rfaddrw <= rf_addrw;
	end

	always_comb begin
		sel_a = forw_sel(id_insn[20:16]);
		sel_b = sel_imm ? SEL_IMM : forw_sel(id_insn[15:11]);
	end

endmodule

`default_nettype wire

// File: rtl/pipe_ctrl.sv
// Top of the decode control block.
// Combines the flush sources and connects the latch, decode and
// forwarding stages; HAS_MUL and HAS_DIV pass down to the EX decoder.
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl import ctrl_pkg::*; #(
	parameter bit HAS_MUL = 1'b1,
	parameter bit HAS_DIV = 1'b1
) (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  id_freeze,
	input  wire logic                  ex_freeze,
	input  wire logic                  wb_freeze,
	input  wire logic                  except_flushpipe,
	input  wire logic                  extend_flush,
	input  wire logic                  pc_we,
	input  wire logic [INSN_W-1:0]     if_insn,
	input  wire logic                  wbforw_valid,
	output logic                       flushpipe,
	output logic      [INSN_W-1:0]     id_insn,
	output logic      [INSN_W-1:0]     ex_insn,
	output logic      [INSN_W-1:0]     wb_insn,
	output branch_op_t                 id_branch_op,
	output branch_op_t                 ex_branch_op,
	output alu_op_t                    alu_op,
	output rfwb_op_t                   rfwb_op,
	output logic      [REG_ADDR_W-1:0] rf_addrw,
	output logic      [INSN_W-1:0]     ex_simm,
	output sel_t                       sel_a,
	output sel_t                       sel_b,
	output logic                       except_illegal,
	output logic                       sig_syscall,
	output logic                       sig_trap
);

	logic              ex_bubble;
	logic              sel_imm;
	logic [INSN_W-1:0] id_simm;

	// one flush level for every stage
	assign flushpipe = except_flushpipe || extend_flush || pc_we;

	////////////////////////////////
	// stages
	////////////////////////////////
	insn_pipe_latch insn_pipe_latch_i (
		.clk, .reset, .flushpipe, .id_freeze, .ex_freeze, .wb_freeze,
		.if_insn, .id_insn, .ex_insn, .wb_insn, .ex_bubble
	);

	id_decode id_decode_i (
		.clk, .reset, .flushpipe, .id_freeze, .if_insn, .id_insn,
		.id_branch_op, .sel_imm, .id_simm
	);

	ex_decode #(.HAS_MUL(HAS_MUL), .HAS_DIV(HAS_DIV)) ex_decode_i (
		.clk, .reset, .ex_freeze, .ex_bubble, .id_insn, .id_branch_op, .id_simm,
		.alu_op, .rfwb_op, .rf_addrw, .ex_branch_op, .ex_simm,
		.except_illegal, .sig_syscall, .sig_trap
	);

	operand_forward operand_forward_i (
		.clk, .reset, .wb_freeze, .id_insn, .sel_imm, .rf_addrw, .rfwb_op,
		.wbforw_valid, .sel_a, .sel_b
	);

endmodule

`default_nettype wire

// File: verif/pipe_ctrl_tb.sv
// Testbench for the decode control block.
// Reads one stimulus line per cycle from verif/ctrl_stim.txt, drives the
// inputs on the rising edge and checks the outputs on the falling edge.
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl_tb import ctrl_pkg::*; ();

	localparam int MAX_LINES  = 64;
	localparam int NUM_COLS   = 19;
	localparam int RESET_CYC  = 8;

	logic              clk;
	logic              reset;
	logic              id_freeze;
	logic              ex_freeze;
	logic              wb_freeze;
	logic              except_flushpipe;
	logic              extend_flush;
	logic              pc_we;
	logic [INSN_W-1:0] if_insn;
	logic              wbforw_valid;

	logic                  flushpipe;
	logic [INSN_W-1:0]     id_insn;
	logic [INSN_W-1:0]     ex_insn;
	logic [INSN_W-1:0]     wb_insn;
	branch_op_t            id_branch_op;
	branch_op_t            ex_branch_op;
	alu_op_t               alu_op;
	rfwb_op_t              rfwb_op;
	logic [REG_ADDR_W-1:0] rf_addrw;
	logic [INSN_W-1:0]     ex_simm;
	sel_t                  sel_a;
	sel_t                  sel_b;
	logic                  except_illegal;
	logic                  sig_syscall;
	logic                  sig_trap;

	// stimulus table, columns as in the data file
	logic [31:0] stim [MAX_LINES][NUM_COLS];
	int          num_lines;
	int          checks;
	int          errors;
	int          cycles;
	int          cycle_limit;

	// expected contents of the instruction registers
	logic [INSN_W-1:0] exp_id_insn;
	logic [INSN_W-1:0] exp_ex_insn;
	logic [INSN_W-1:0] exp_wb_insn;

	pipe_ctrl #(.HAS_MUL(1'b1), .HAS_DIV(1'b1)) pipe_ctrl_i (
		.clk, .reset, .id_freeze, .ex_freeze, .wb_freeze,
		.except_flushpipe, .extend_flush, .pc_we, .if_insn, .wbforw_valid,
		.flushpipe, .id_insn, .ex_insn, .wb_insn, .id_branch_op, .ex_branch_op,
		.alu_op, .rfwb_op, .rf_addrw, .ex_simm, .sel_a, .sel_b,
		.except_illegal, .sig_syscall, .sig_trap
	);

	always #20 clk = ~clk;

	////////////////////////////////
	// run limit
	////////////////////////////////
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// loads every data line, skipping comments and blank lines
	task automatic load_stim(output bit ok);
		int          fd;
		int          n;
		int          code;
		string       line;
		logic [31:0] v [NUM_COLS];
		ok = 1'b1;
		num_lines = 0;
		fd = $fopen("verif/ctrl_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file verif/ctrl_stim.txt");
			ok = 1'b0;
		end else begin
			while (!$feof(fd) && ok) begin
				code = $fgets(line, fd);
				if (code > 1 && line[0] != "#" && num_lines < MAX_LINES) begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
						v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
					if (n != NUM_COLS) begin
						$display("stimulus line %0d has %0d fields instead of %0d",
							num_lines, n, NUM_COLS);
						ok = 1'b0;
					end else begin
						for (int c = 0; c < NUM_COLS; c++)
							stim[num_lines][c] = v[c];
						num_lines++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected, input int line_no);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("FAIL %0d ns: line %0d %s got %h expected %h",
				$time, line_no, name, got, expected);
		end
	endtask

	// any of the three flush sources on line k
	function automatic logic line_flushes(input int k);
		return stim[k][3][0] || stim[k][4][0] || stim[k][5][0];
	endfunction

	task automatic apply_line(input int k);
		id_freeze        <= stim[k][0][0];
		ex_freeze        <= stim[k][1][0];
		wb_freeze        <= stim[k][2][0];
		except_flushpipe <= stim[k][3][0];
		extend_flush     <= stim[k][4][0];
		pc_we            <= stim[k][5][0];
		wbforw_valid     <= stim[k][6][0];
		if_insn          <= stim[k][7];
	endtask

	task automatic compare_line(input int k);
		check_value("alu_op", 32'(alu_op), stim[k][8], k);
		check_value("rfwb_op", 32'(rfwb_op), stim[k][9], k);
		check_value("rf_addrw", 32'(rf_addrw), stim[k][10], k);
		check_value("ex_branch_op", 32'(ex_branch_op), stim[k][11], k);
		check_value("ex_simm", ex_simm, stim[k][12], k);
		check_value("except_illegal", 32'(except_illegal), stim[k][13], k);
		check_value("sig_syscall", 32'(sig_syscall), stim[k][14], k);
		check_value("sig_trap", 32'(sig_trap), stim[k][15], k);
		check_value("sel_a", 32'(sel_a), stim[k][16], k);
		check_value("sel_b", 32'(sel_b), stim[k][17], k);
		check_value("flushpipe", 32'(flushpipe), stim[k][18], k);
		check_value("id_insn", id_insn, exp_id_insn, k);
		check_value("ex_insn", ex_insn, exp_ex_insn, k);
		check_value("wb_insn", wb_insn, exp_wb_insn, k);
		// id branch op reaches ex at the next edge when nothing holds it back
		if (k + 1 < num_lines && !stim[k][0][0] && !stim[k][1][0] && !line_flushes(k))
			check_value("id_branch_op", 32'(id_branch_op), stim[k + 1][11], k);
	endtask

	// instruction registers after the edge that samples line k
	task automatic advance_model(input int k);
		logic flush;
		logic bubble;
		flush  = line_flushes(k);
		bubble = (!stim[k][1][0] && stim[k][0][0]) || flush;
		if (!stim[k][2][0])
			exp_wb_insn = exp_ex_insn;
		if (bubble)
			exp_ex_insn = NOP_INSN;
		else if (!stim[k][1][0])
			exp_ex_insn = exp_id_insn;
		if (flush)
			exp_id_insn = NOP_INSN;
		else if (!stim[k][0][0])
			exp_id_insn = stim[k][7];
	endtask

	////////////////////////////////
	// main sequence
	////////////////////////////////
	initial begin
		bit ok;
		clk              = 1'b0;
		reset            = 1'b1;
		id_freeze        = 1'b0;
		ex_freeze        = 1'b0;
		wb_freeze        = 1'b0;
		except_flushpipe = 1'b0;
		extend_flush     = 1'b0;
		pc_we            = 1'b0;
		wbforw_valid     = 1'b0;
		if_insn          = NOP_INSN;
		checks           = 0;
		errors           = 0;
		cycles           = 0;
		cycle_limit      = 0;
		exp_id_insn      = NOP_INSN;
		exp_ex_insn      = NOP_INSN;
		exp_wb_insn      = NOP_INSN;
		load_stim(ok);
		if (!ok || num_lines == 0) begin
			$display("no usable stimulus, nothing was checked");
			$display("*** FAILED ***");
			$finish;
		end else begin
			cycle_limit = num_lines + RESET_CYC + 20;
			repeat (RESET_CYC - 1) @(posedge clk);
			// first line goes in on the last reset edge
			@(posedge clk);
			reset <= 1'b0;
			for (int k = 0; k < num_lines; k++) begin
				if (k > 0)
					@(posedge clk);
				apply_line(k);
				@(negedge clk);
				compare_line(k);
				advance_model(k);
			end
			$display("checks %0d, errors %0d", checks, errors);
			if (errors == 0) begin
				$display("*** PASSED ***");
			end else begin
				$display("*** FAILED ***");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verif/ctrl_stim.txt
# idf exf wbf exc_fl ext_fl pc_we wbforw if_insn | expected: alu rfwb addrw ex_br simm
# illegal syscall trap sel_a sel_b flushpipe (all hex, one line per cycle)
0 0 0 0 0 0 0 9C61FFF0 10 0 00 0 00000000 0 0 0 0 0 0
0 0 0 0 0 0 0 9C830005 10 0 0A 0 00000000 0 0 0 0 1 0
0 0 0 0 0 0 0 A8A38001 00 1 03 0 FFFFFFF0 0 0 0 2 1 0
0 0 0 0 0 0 1 18C01234 00 1 04 0 00000005 0 0 0 3 1 0
0 0 0 0 0 0 0 E0E42800 04 1 05 0 00008001 0 0 0 0 1 0
0 0 0 0 0 0 1 04000010 0E 1 06 0 00001234 0 0 0 0 3 0
0 0 0 0 0 0 0 D7E21923 00 1 07 0 00002800 0 0 0 0 1 0
0 0 0 0 0 0 0 C0412456 10 7 09 1 00000010 0 0 0 0 0 0
0 0 0 0 0 0 0 FC000000 10 0 1F 0 FFFFF923 0 0 0 0 0 0
0 0 0 0 0 0 0 E000000C 10 0 02 0 00001456 0 0 0 0 1 0
0 0 0 0 0 0 0 E1000009 10 0 00 0 00000000 1 0 0 0 0 0
0 0 0 0 0 0 0 20000000 0C 1 00 0 0000000C 1 0 0 2 2 0
0 0 0 0 0 0 1 21000000 09 1 08 0 00000009 0 0 0 3 3 0
0 0 0 0 0 0 0 10000003 10 0 00 0 00000000 0 1 0 0 0 0
0 0 0 0 0 0 0 9D600002 10 0 08 0 00000000 0 0 1 0 1 0
0 0 0 0 1 0 0 9D400001 10 0 00 4 00000003 0 0 0 0 1 1
0 0 0 0 0 0 0 A98000FF 10 0 00 0 00000000 0 0 0 0 1 0
1 0 0 0 0 0 0 9D400001 10 0 0A 0 00000000 0 0 0 0 1 0
0 0 0 0 0 0 0 9DA00003 10 0 00 0 00000000 0 0 0 0 1 0
1 1 0 0 0 0 0 15410000 04 1 0C 0 000000FF 0 0 0 0 1 0
0 0 0 0 0 0 0 15410000 04 1 0C 0 000000FF 0 0 0 0 1 0
0 0 0 0 0 0 0 15410000 00 1 0D 0 00000003 0 0 0 0 0 0
0 0 0 0 0 0 0 15410000 10 0 0A 0 00000000 0 0 0 0 0 0
0 0 0 0 0 0 0 15410000 10 0 0A 0 00000000 0 0 0 0 0 0

// File: sources.f
rtl/ctrl_pkg.sv
rtl/insn_pipe_latch.sv
rtl/id_decode.sv
rtl/ex_decode.sv
rtl/operand_forward.sv
rtl/pipe_ctrl.sv
verif/pipe_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the decode control testbench with Verilator.
# Run from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f sources.f \
	--top-module pipe_ctrl_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$OBJ/Vpipe_ctrl_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
	exit 1
fi
exit 0
